/* hw/fe_buf.sv */
`timescale 1ns/1ps
`include "fe_cfg.svh"

module fe_buf (
    input  logic            clk,
    input  logic            reset,
    input  fe_pkg::t_fe_req fe_req,
    output fe_pkg::t_fe_rsp fe_rsp,
    output logic            fe_ready,
    input  fe_pkg::t_fe_req pf_req,
    output logic            pf_taken,
    output fe_pkg::t_wb_req wb_req,
    input  fe_pkg::t_wb_rsp wb_rsp
);

    localparam int OFF_BITS = `FE_LINE_OFF_BITS;
    localparam int LA_BITS  = `FE_ADDR_BITS - OFF_BITS;
    localparam int NUM_SETS = `FE_FB_NUM_SETS;
    localparam int NUM_ENTS = `FE_FB_NUM_ENTS;
    localparam int ENT_BITS = `FE_FB_ENT_BITS;

    function automatic logic [LA_BITS-1:0] line_addr(logic [`FE_ADDR_BITS-1:0] addr);
        return addr[`FE_ADDR_BITS-1:OFF_BITS];
    endfunction

    function automatic logic [`FE_FB_SET_BITS-1:0] set_of(logic [`FE_ADDR_BITS-1:0] addr);
        return addr[OFF_BITS +: `FE_FB_SET_BITS];
    endfunction

    // Upper word for the odd instruction of a line
    function automatic logic [`FE_INSTR_BITS-1:0] pick_instr(
        logic [`FE_LINE_BITS-1:0] data,
        logic [`FE_ADDR_BITS-1:0] addr
    );
        return addr[OFF_BITS-1] ? data[`FE_LINE_BITS-1 -: `FE_INSTR_BITS]
                                : data[`FE_INSTR_BITS-1:0];
    endfunction

    // Line store
    logic [NUM_SETS-1:0]      store_valid;
    logic [LA_BITS-1:0]       store_addr [NUM_SETS];
    logic [`FE_LINE_BITS-1:0] store_data [NUM_SETS];

    // Miss entries
    logic [NUM_ENTS-1:0]      ent_push;
    logic [NUM_ENTS-1:0]      ent_grant;
    logic [NUM_ENTS-1:0]      ent_ack;
    logic [NUM_ENTS-1:0]      ent_deliver;
    logic [NUM_ENTS-1:0]      ent_idle;
    logic [NUM_ENTS-1:0]      ent_pf_match;
    fe_pkg::t_fb_static       ent_info  [NUM_ENTS];
    fe_pkg::t_ent_state       ent_state [NUM_ENTS];
    logic [`FE_LINE_BITS-1:0] ent_line  [NUM_ENTS];
    fe_pkg::t_fb_static       push_info;

    logic [`FE_FB_SET_BITS-1:0] req_set;
    logic [`FE_FB_SET_BITS-1:0] pf_set;
    logic [`FE_FB_SET_BITS-1:0] fill_set;
    logic                       hit;
    logic                       miss_push;
    logic                       pf_dup;
    logic                       pf_push;
    logic                       any_push;
    logic [ENT_BITS:0]          idle_cnt;
    logic [ENT_BITS-1:0]        free_idx;
    logic [ENT_BITS-1:0]        wait_idx;
    logic [ENT_BITS-1:0]        req_idx;
    logic [ENT_BITS-1:0]        rsp_idx;
    logic [ENT_BITS-1:0]        owner;
    logic                       has_wait;
    logic                       any_req;
    logic                       any_rsp;
    logic                       bus_active;
    logic                       ack_q;
    fe_pkg::t_fe_rsp            rsp_nxt;

    // Hit check against the direct-mapped store
    assign req_set   = set_of(fe_req.addr);
    assign hit       = fe_req.valid && store_valid[req_set]
                       && (store_addr[req_set] == line_addr(fe_req.addr));
    assign miss_push = fe_req.valid && !hit;

    // Entry scans where the lowest index wins each search
    always_comb begin
        idle_cnt = '0;
        free_idx = '0;
        wait_idx = '0;
        req_idx  = '0;
        rsp_idx  = '0;
        has_wait = 1'b0;
        any_req  = 1'b0;
        any_rsp  = 1'b0;
        for (int i = NUM_ENTS - 1; i >= 0; i--) begin
            ent_idle[i]     = (ent_state[i] == fe_pkg::ENT_IDLE);
            ent_pf_match[i] = !ent_idle[i]
                              && (line_addr(ent_info[i].req.addr) == line_addr(pf_req.addr));
            idle_cnt        = idle_cnt + (ENT_BITS + 1)'(ent_idle[i]);
            if (ent_idle[i]) begin
                free_idx = ENT_BITS'(i);
            end
            if (ent_state[i] == fe_pkg::ENT_WAIT) begin
                has_wait = 1'b1;
                wait_idx = ENT_BITS'(i);
            end
            if (ent_state[i] == fe_pkg::ENT_REQ) begin
                any_req = 1'b1;
                req_idx = ENT_BITS'(i);
            end
            if (ent_state[i] == fe_pkg::ENT_RSP) begin
                any_rsp = 1'b1;
                rsp_idx = ENT_BITS'(i);
            end
        end
    end

    // A duplicate prefetch is consumed without allocating
    assign pf_set   = set_of(pf_req.addr);
    assign pf_dup   = (|ent_pf_match) || (store_valid[pf_set]
                      && (store_addr[pf_set] == line_addr(pf_req.addr)));
    assign pf_push  = pf_req.valid && !miss_push && !pf_dup && (idle_cnt != 0);
    assign pf_taken = pf_req.valid && !miss_push && (pf_dup || pf_push);
    assign any_push = miss_push || pf_push;

    // An entry must still be free next cycle after this cycle's push
    assign fe_ready = (idle_cnt > 1) || ((idle_cnt == 1) && !any_push);

    always_comb begin
        push_info.req = miss_push ? fe_req : pf_req;
        push_info.pf  = !miss_push;
        ent_push      = '0;
        if (any_push) begin
            ent_push[free_idx] = 1'b1;
        end
    end

    for (genvar i = 0; i < NUM_ENTS; i++) begin : g_ent
        fe_fb_entry ent_i (
            .clk      (clk),
            .reset    (reset),
            .push     (ent_push[i]),
            .push_info(push_info),
            .info     (ent_info[i]),
            .state    (ent_state[i]),
            .grant    (ent_grant[i]),
            .ack      (ent_ack[i]),
            .ack_line (wb_rsp.dat_i),
            .line     (ent_line[i]),
            .deliver  (ent_deliver[i])
        );
    end

    // Wishbone owner is the waiting entry or else the lowest requester.
    // Bus stays idle for one cycle after each ack.
    assign owner      = has_wait ? wait_idx : req_idx;
    assign bus_active = has_wait || (any_req && !ack_q);
    assign fill_set   = set_of(ent_info[owner].req.addr);

    always_comb begin
        wb_req.cyc = bus_active;
        wb_req.stb = bus_active;
        wb_req.we  = 1'b0;
        wb_req.adr = {line_addr(ent_info[owner].req.addr), {OFF_BITS{1'b0}}};
        ent_grant  = '0;
        if (bus_active) begin
            ent_grant[owner] = 1'b1;
        end
        ent_ack = ent_grant & {NUM_ENTS{wb_rsp.ack}};
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            ack_q       <= 1'b0;
            store_valid <= '0;
        end else begin
            ack_q <= bus_active && wb_rsp.ack;
            if (bus_active && wb_rsp.ack) begin
                store_valid[fill_set] <= 1'b1;
            end
        end
    end

    // Fill on ack for demand and prefetch alike
    always_ff @(posedge clk) begin
        if (bus_active && wb_rsp.ack) begin
            store_addr[fill_set] <= line_addr(ent_info[owner].req.addr);
            store_data[fill_set] <= wb_rsp.dat_i;
        end
    end

    // Response mux with hits before completed misses
    always_comb begin
        rsp_nxt     = '0;
        ent_deliver = '0;
        if (hit) begin
            rsp_nxt.valid = 1'b1;
            rsp_nxt.tag   = fe_req.tag;
            rsp_nxt.pc    = fe_req.addr;
            rsp_nxt.instr = pick_instr(store_data[req_set], fe_req.addr);
        end else if (any_rsp) begin
            rsp_nxt.valid        = 1'b1;
            rsp_nxt.tag          = ent_info[rsp_idx].req.tag;
            rsp_nxt.pc           = ent_info[rsp_idx].req.addr;
            rsp_nxt.instr        = pick_instr(ent_line[rsp_idx], ent_info[rsp_idx].req.addr);
            ent_deliver[rsp_idx] = 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            fe_rsp <= '0;
        end else begin
            fe_rsp <= rsp_nxt;
        end
    end

    // Cyc and stb both drop in the cycle after ack
    a_drop_after_ack: assert property (
        @(posedge clk) disable iff (reset)
        (wb_req.stb && wb_rsp.ack) |=> !(wb_req.cyc || wb_req.stb)
    );

    // Classic read holds until ack
    a_adr_stable: assert property (
        @(posedge clk) disable iff (reset)
        (wb_req.stb && !wb_rsp.ack) |=> (wb_req.stb && $stable(wb_req.adr))
    );

    a_ready_respected: assert property (
        @(posedge clk) disable iff (reset)
        !fe_ready |=> !fe_req.valid
    );

endmodule

/* hw/fe_fb_entry.sv */
`timescale 1ns/1ps
`include "fe_cfg.svh"

module fe_fb_entry (
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     push,
    input  fe_pkg::t_fb_static       push_info,
    output fe_pkg::t_fb_static       info,
    output fe_pkg::t_ent_state       state,
    input  logic                     grant,
    input  logic                     ack,
    input  logic [`FE_LINE_BITS-1:0] ack_line,
    output logic [`FE_LINE_BITS-1:0] line,
    input  logic                     deliver
);

    fe_pkg::t_ent_state done_state;

    // Prefetches only fill the store, so they skip the response step
    assign done_state = info.pf ? fe_pkg::ENT_IDLE : fe_pkg::ENT_RSP;

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= fe_pkg::ENT_IDLE;
        end else begin
            case (state)
                fe_pkg::ENT_IDLE: begin
                    if (push) begin
                        state <= fe_pkg::ENT_REQ;
                    end
                end
                fe_pkg::ENT_REQ: begin
                    // Memory may ack in the very cycle the read is first driven
                    if (grant && ack) begin
                        state <= done_state;
                    end else if (grant) begin
                        state <= fe_pkg::ENT_WAIT;
                    end
                end
                fe_pkg::ENT_WAIT: begin
                    if (ack) begin
                        state <= done_state;
                    end
                end
                fe_pkg::ENT_RSP: begin
                    if (deliver) begin
                        state <= fe_pkg::ENT_IDLE;
                    end
                end
                default: begin
                    state <= fe_pkg::ENT_IDLE;
                end
            endcase
        end
    end

    // Request and returned line
    always_ff @(posedge clk) begin
        if (push) begin
            info <= push_info;
        end
        if (ack) begin
            line <= ack_line;
        end
    end

    // Allocation in fe_buf must only pick a free entry
    a_push_idle: assert property (
        @(posedge clk) disable iff (reset)
        push |-> state == fe_pkg::ENT_IDLE
    );

endmodule

/* hw/fe_pf.sv */
`timescale 1ns/1ps
`include "fe_cfg.svh"

module fe_pf (
    input  logic            clk,
    input  logic            reset,
    input  fe_pkg::t_fe_req fe_req,
    output fe_pkg::t_fe_req pf_req,
    input  logic            pf_taken
);

    localparam int OFF_BITS = `FE_LINE_OFF_BITS;
    localparam int LA_BITS  = `FE_ADDR_BITS - OFF_BITS;

    logic [LA_BITS-1:0] next_line;
    logic [LA_BITS-1:0] pf_line;
    logic               pf_valid;
    logic               have_line;
    logic               is_repeat;

    // Line following the one the front end asked for
    assign next_line = fe_req.addr[`FE_ADDR_BITS-1:OFF_BITS] + LA_BITS'(1);

    // Same line as last proposed, nothing new to offer
    assign is_repeat = have_line && (next_line == pf_line);

    always_ff @(posedge clk) begin
        if (reset) begin
            pf_valid  <= 1'b0;
            have_line <= 1'b0;
        end else begin
            if (pf_taken) begin
                pf_valid <= 1'b0;
            end
            // A newer request replaces a candidate still waiting
            if (fe_req.valid && !is_repeat) begin
                pf_valid  <= 1'b1;
                have_line <= 1'b1;
            end
        end
    end

    // pf_line doubles as the last proposed line
    always_ff @(posedge clk) begin
        if (fe_req.valid && !is_repeat) begin
            pf_line <= next_line;
        end
    end

    always_comb begin
        pf_req.valid = pf_valid;
        pf_req.tag   = '0;
        pf_req.addr  = {pf_line, {OFF_BITS{1'b0}}};
    end

endmodule

/* hw/fe_pkg.sv */
`include "fe_cfg.svh"

package fe_pkg;

    // Fetch request from the front end or the prefetcher
    typedef struct packed {
        logic                     valid;
        logic [`FE_TAG_BITS-1:0]  tag;
        logic [`FE_ADDR_BITS-1:0] addr;
    } t_fe_req;

    // Fetch response back to the front end
    typedef struct packed {
        logic                      valid;
        logic [`FE_TAG_BITS-1:0]   tag;
        logic [`FE_ADDR_BITS-1:0]  pc;
        logic [`FE_INSTR_BITS-1:0] instr;
    } t_fe_rsp;

    // What a miss entry keeps for its whole life
    typedef struct packed {
        t_fe_req req;
        logic    pf;
    } t_fb_static;

    // Wishbone classic master outputs
    typedef struct packed {
        logic                     cyc;
        logic                     stb;
        logic                     we;
        logic [`FE_ADDR_BITS-1:0] adr;
    } t_wb_req;

    // Wishbone classic slave outputs
    typedef struct packed {
        logic                     ack;
        logic [`FE_LINE_BITS-1:0] dat_i;
    } t_wb_rsp;

    // Miss entry life cycle
    typedef enum logic [1:0] {
        ENT_IDLE,
        ENT_REQ,
        ENT_WAIT,
        ENT_RSP
    } t_ent_state;

endpackage

/* hw/fetch_unit.sv */
`timescale 1ns/1ps

module fetch_unit (
    input  logic            clk,
    input  logic            reset,
    input  fe_pkg::t_fe_req fe_req,
    output fe_pkg::t_fe_rsp fe_rsp,
    output logic            fe_ready,
    output fe_pkg::t_wb_req wb_req,
    input  fe_pkg::t_wb_rsp wb_rsp
);

    fe_pkg::t_fe_req pf_req;
    logic            pf_taken;

    fe_buf fe_buf_i (
        .clk     (clk),
        .reset   (reset),
        .fe_req  (fe_req),
        .fe_rsp  (fe_rsp),
        .fe_ready(fe_ready),
        .pf_req  (pf_req),
        .pf_taken(pf_taken),
        .wb_req  (wb_req),
        .wb_rsp  (wb_rsp)
    );

    // Next-line prefetch follows every front-end request
    fe_pf fe_pf_i (
        .clk     (clk),
        .reset   (reset),
        .fe_req  (fe_req),
        .pf_req  (pf_req),
        .pf_taken(pf_taken)
    );

endmodule

/* include/fe_cfg.svh */
`ifndef FE_CFG_SVH
`define FE_CFG_SVH

// Byte address and instruction widths
`define FE_ADDR_BITS      16
`define FE_INSTR_BITS     32

// A line holds two instructions and is also the Wishbone data width
`define FE_LINE_BITS      64
`define FE_LINE_OFF_BITS  3

// Direct-mapped line store, set index sits just above the line offset
`define FE_FB_NUM_SETS    4
`define FE_FB_SET_BITS    2

// Miss entries
`define FE_FB_NUM_ENTS    4
`define FE_FB_ENT_BITS    2

// Front-end request tag
`define FE_TAG_BITS       4

`endif

/* run_sim.sh */
#!/bin/sh
# Build and run the fetch unit testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert \
    -f verilog.f \
    --top-module tb_fetch_unit \
    -o tb_fetch_unit_sim

./obj_dir/tb_fetch_unit_sim > sim.log 2>&1
cat sim.log

if grep -q "^>>> PASS$" sim.log; then
    echo "Simulation passed"
    exit 0
else
    echo "Simulation failed"
    exit 1
fi

/* testbench/tb_fetch_tests.svh */
`ifndef TB_FETCH_TESTS_SVH
`define TB_FETCH_TESTS_SVH

// Send one request once ready allows it and record what should come back
task automatic issue(input logic [`FE_ADDR_BITS-1:0] addr, output logic [`FE_TAG_BITS-1:0] tag);
    t_expect e;
    @(posedge clk);
    while (!fe_ready) @(posedge clk);
    tag      = next_tag;
    next_tag = next_tag + 4'd1;
    e.tag    = tag;
    e.pc     = addr;
    e.instr  = instr_at(addr);
    exp_q.push_back(e);
    fe_req.valid <= 1'b1;
    fe_req.tag   <= tag;
    fe_req.addr  <= addr;
    @(posedge clk);
    fe_req.valid <= 1'b0;
endtask

// Response must be in the cycle right after the request
task automatic expect_hit_next(input logic [`FE_TAG_BITS-1:0] tag);
    @(negedge clk);
    check("hit rsp valid", 64'(fe_rsp.valid), 64'(1));
    check("hit rsp tag", 64'(fe_rsp.tag), 64'(tag));
endtask

task automatic drain(input int max_cycles);
    int n;
    n = 0;
    while (exp_q.size() != 0 && n < max_cycles) begin
        @(negedge clk);
        n++;
    end
    if (exp_q.size() != 0) begin
        note_failure("some requests never got a response");
        exp_q.delete();
    end
endtask

task automatic settle();
    repeat (30) @(posedge clk);
endtask

function automatic bit read_seen(input logic [`FE_ADDR_BITS-1:0] line);
    bit found;
    found = 1'b0;
    foreach (rd_log[i]) begin
        if (rd_log[i] == line) begin
            found = 1'b1;
        end
    end
    return found;
endfunction

task automatic wait_read(input logic [`FE_ADDR_BITS-1:0] line, input int max_cycles);
    int n;
    n = 0;
    while (!read_seen(line) && n < max_cycles) begin
        @(posedge clk);
        n++;
    end
    if (!read_seen(line)) begin
        note_failure($sformatf("no Wishbone read of line %0h", line));
    end
endtask

task automatic test_reset_state();
    logic [`FE_TAG_BITS-1:0] t;
    @(negedge clk);
    check("reset cyc", 64'(wb_req.cyc), 64'(0));
    check("reset stb", 64'(wb_req.stb), 64'(0));
    check("reset rsp valid", 64'(fe_rsp.valid), 64'(0));
    check("reset ready", 64'(fe_ready), 64'(1));
    rd_log.delete();
    issue(16'h0104, t);
    drain(500);
    wait_read(16'h0100, 10);
endtask

task automatic test_hit();
    logic [`FE_TAG_BITS-1:0] t;
    issue(16'h0100, t);
    expect_hit_next(t);
    issue(16'h0104, t);
    expect_hit_next(t);
    drain(10);
endtask

// Four sets at once, any return order
task automatic test_multi_miss();
    logic [`FE_TAG_BITS-1:0] t;
    settle();
    issue(16'h1000, t);
    issue(16'h104C, t);
    issue(16'h1090, t);
    issue(16'h10DC, t);
    drain(1000);
endtask

task automatic test_back_pressure();
    logic [`FE_TAG_BITS-1:0] t;
    int                      n;
    settle();
    @(posedge clk);
    mem_stall <= 1'b1;
    fork
        begin
            issue(16'h4000, t);
            issue(16'h4048, t);
            issue(16'h4090, t);
            issue(16'h40D8, t);
            issue(16'h4124, t);
        end
        begin
            n = 0;
            @(posedge clk);
            while (fe_ready && n < 200) begin
                @(posedge clk);
                n++;
            end
            if (fe_ready) begin
                note_failure("ready never went low with all entries busy");
            end else begin
                repeat (10) @(posedge clk);
                check("ready low while stalled", 64'(fe_ready), 64'(0));
            end
            mem_stall <= 1'b0;
        end
    join
    drain(1000);
endtask

task automatic test_prefetch();
    logic [`FE_TAG_BITS-1:0] t;
    settle();
    rd_log.delete();
    issue(16'h6000, t);
    drain(500);
    wait_read(16'h6008, 200);
    issue(16'h600C, t);
    expect_hit_next(t);
    drain(10);
endtask

// 0x7000 and 0x7020 share set 0
task automatic test_conflict();
    logic [`FE_TAG_BITS-1:0] t;
    settle();
    for (int round = 0; round < 2; round++) begin
        rd_log.delete();
        issue(16'h7004, t);
        drain(500);
        wait_read(16'h7000, 10);
        rd_log.delete();
        issue(16'h7020, t);
        drain(500);
        wait_read(16'h7020, 10);
    end
endtask

`endif

/* testbench/tb_fetch_unit.sv */
`timescale 1ns/1ps
`include "fe_cfg.svh"

module tb_fetch_unit;

    localparam int NUM_TESTS = 6;
    // Applied to every memory word so data never equals a plain address
    localparam logic [`FE_INSTR_BITS-1:0] DATA_XOR = 32'h5A3C_96E1;

    typedef struct packed {
        logic [`FE_TAG_BITS-1:0]   tag;
        logic [`FE_ADDR_BITS-1:0]  pc;
        logic [`FE_INSTR_BITS-1:0] instr;
    } t_expect;

    logic                    clk;
    logic                    reset;
    fe_pkg::t_fe_req         fe_req;
    fe_pkg::t_fe_rsp         fe_rsp;
    logic                    fe_ready;
    fe_pkg::t_wb_req         wb_req;
    fe_pkg::t_wb_rsp         wb_rsp;

    integer                  seed;
    int                      errors;
    logic                    mem_stall;
    logic [`FE_TAG_BITS-1:0] next_tag;
    t_expect                 exp_q [$];
    logic [`FE_ADDR_BITS-1:0] rd_log [$];

    fetch_unit fetch_unit_i (
        .clk     (clk),
        .reset   (reset),
        .fe_req  (fe_req),
        .fe_rsp  (fe_rsp),
        .fe_ready(fe_ready),
        .wb_req  (wb_req),
        .wb_rsp  (wb_rsp)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // Memory word at a byte address: the word address in both halves
    function automatic logic [`FE_INSTR_BITS-1:0] instr_at(input logic [`FE_ADDR_BITS-1:0] a);
        logic [`FE_ADDR_BITS-1:0] w;
        w = {a[`FE_ADDR_BITS-1:2], 2'b00};
        return {w, w} ^ DATA_XOR;
    endfunction

    function automatic logic [`FE_LINE_BITS-1:0] line_data(input logic [`FE_ADDR_BITS-1:0] adr);
        return {instr_at(adr + 16'd4), instr_at(adr)};
    endfunction

    task automatic check(input string what, input logic [63:0] got, input logic [63:0] exp);
        if (got !== exp) begin
            errors++;
            $display("ERR %0t ns: %s: got %0h, expected %0h", $time, what, got, exp);
        end
    endtask

    task automatic note_failure(input string msg);
        errors++;
        $display("Failure at %0t ns: %s", $time, msg);
    endtask

    // Wishbone classic responder with 0 to 3 random wait cycles
    task automatic memory_model();
        logic                     in_read;
        logic                     just_acked;
        logic [`FE_ADDR_BITS-1:0] cur_adr;
        int                       wait_cnt;
        in_read    = 1'b0;
        just_acked = 1'b0;
        cur_adr    = '0;
        wait_cnt   = 0;
        forever begin
            @(posedge clk);
            if (reset) begin
                wb_rsp     <= '0;
                in_read    = 1'b0;
                just_acked = 1'b0;
            end else if (wb_rsp.ack) begin
                wb_rsp.ack <= 1'b0;
                in_read    = 1'b0;
                just_acked = 1'b1;
                rd_log.push_back(cur_adr);
            end else begin
                if (just_acked && wb_req.stb) begin
                    note_failure("stb still high in the cycle after ack");
                end
                just_acked = 1'b0;
                if (wb_req.stb) begin
                    if (!wb_req.cyc) begin
                        note_failure("stb high without cyc");
                    end
                    if (wb_req.we) begin
                        note_failure("write cycle seen on a read-only port");
                    end
                    if (!in_read) begin
                        in_read  = 1'b1;
                        cur_adr  = wb_req.adr;
                        wait_cnt = int'($unsigned($random(seed)) % 32'd4);
                    end else begin
                        check("wb adr stable", 64'(wb_req.adr), 64'(cur_adr));
                    end
                    if (!mem_stall) begin
                        if (wait_cnt == 0) begin
                            wb_rsp.ack   <= 1'b1;
                            wb_rsp.dat_i <= line_data(cur_adr);
                        end else begin
                            wait_cnt--;
                        end
                    end
                end
            end
        end
    endtask

    // Scoreboard, matches responses by tag in any order
    task automatic response_monitor();
        int idx;
        forever begin
            @(negedge clk);
            if (fe_rsp.valid) begin
                idx = -1;
                foreach (exp_q[i]) begin
                    if (idx < 0 && exp_q[i].tag == fe_rsp.tag) begin
                        idx = i;
                    end
                end
                if (idx < 0) begin
                    note_failure("response with a tag that has no pending request");
                end else begin
                    check("rsp pc", 64'(fe_rsp.pc), 64'(exp_q[idx].pc));
                    check("rsp instr", 64'(fe_rsp.instr), 64'(exp_q[idx].instr));
                    exp_q.delete(idx);
                end
            end
        end
    endtask

`include "tb_fetch_tests.svh"

    initial begin
        seed      = 73;
        errors    = 0;
        mem_stall = 1'b0;
        next_tag  = '0;
        reset     = 1'b1;
        fe_req    = '0;
        wb_rsp    = '0;
        fork
            memory_model();
            response_monitor();
        join_none
        repeat (2) @(posedge clk);
        reset <= 1'b0;
        test_reset_state();
        test_hit();
        test_multi_miss();
        test_back_pressure();
        test_prefetch();
        test_conflict();
        settle();
        $display("Run complete with %0d errors", errors);
        if (errors == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

    // Watchdog
    initial begin
        repeat (NUM_TESTS * 2000) @(posedge clk);
        $display("Timeout: the tests did not finish in time");
        $display(">>> FAIL");
        $finish;
    end

endmodule

/* verilog.f */
+incdir+include
+incdir+testbench
hw/fe_pkg.sv
hw/fe_fb_entry.sv
hw/fe_pf.sv
hw/fe_buf.sv
hw/fetch_unit.sv
testbench/tb_fetch_unit.sv
